/* logic/psx_params.svh */
`ifndef PSX_PARAMS_SVH
`define PSX_PARAMS_SVH

// serial clock timing, all counts in system clocks
`define PSX_HALF_DIV 4        // psx_clk half period
`define PSX_ACK_TIMEOUT 64    // wait for pad_ack after the last rising edge
`define PSX_SELECT_DELAY 8    // att low to first bit
`define PSX_POLL_GAP 16       // att high between polls

// result flow control
`define PSX_INIT_CREDITS 2    // results the consumer can hold

// command bytes, sent lsb first
`define PSX_CMD_START 8'h01   // wakes the pad
`define PSX_CMD_POLL 8'h42    // read buttons

// second reply after the identity byte
`define PSX_MARKER 8'h5A

`endif

/* logic/psx_pkg.sv */
package psx_pkg;

    typedef logic [7:0] psx_byte_t;     // one byte on the serial link
    typedef logic [15:0] psx_buttons_t; // first received byte in low half, 0 = pressed
    typedef logic [2:0] psx_credit_t;   // outstanding result slots
    typedef logic [2:0] psx_bit_idx_t;  // bit position within a byte

    // single byte shifter
    typedef enum logic [1:0] {
        xfer_idle,
        xfer_shift,
        xfer_wait_ack
    } xfer_state_t;

    // whole poll sequence
    typedef enum logic [2:0] {
        poll_idle,
        poll_select,
        poll_bytes,
        poll_finish,
        poll_gap
    } poll_state_t;

endpackage

/* logic/psx_clk_gen.sv */
`timescale 1ns/1ps
`include "psx_params.svh"

module psx_clk_gen (
    input  logic ack,
    input  logic rst_n,
    input  logic run,      // byte engine wants the serial clock
    output logic psx_clk,
    output logic fall_stb, // psx_clk goes low at the next edge
    output logic rise_stb  // psx_clk goes high at the next edge
);

    localparam int cnt_w = (`PSX_HALF_DIV > 1) ? $clog2(`PSX_HALF_DIV) : 1;
    localparam logic [cnt_w-1:0] half_last = cnt_w'(`PSX_HALF_DIV - 1);

    logic [cnt_w-1:0] div_cnt;
    logic             half_end;

    // last cycle of the current half period
    assign half_end = run && (div_cnt == half_last);

    // psx_clk idles high, so the first edge after run rises is a fall
    assign fall_stb = half_end && psx_clk;
    assign rise_stb = half_end && !psx_clk;

    always_ff @(posedge ack or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            psx_clk <= 1'b1;
        end else if (!run) begin
            div_cnt <= '0;      // restart cleanly for the next byte
            psx_clk <= 1'b1;
        end else if (half_end) begin
            div_cnt <= '0;
            psx_clk <= ~psx_clk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

/* logic/psx_byte_xfer.sv */
`timescale 1ns/1ps
`include "psx_params.svh"

module psx_byte_xfer (
    input  logic                ack,
    input  logic                rst_n,
    input  logic                byte_start,  // one pulse per byte
    input  psx_pkg::psx_byte_t  tx_byte,
    input  logic                want_ack,    // wait for pad_ack after this byte
    input  logic                fall_stb,
    input  logic                rise_stb,
    input  logic                data,        // pad to host
    input  logic                pad_ack,     // active low pulse from the pad
    output logic                run,
    output logic                cmd,         // host to pad
    output psx_pkg::psx_byte_t  rx_byte,
    output logic                byte_done,
    output logic                ack_missing
);

    localparam int ack_w = (`PSX_ACK_TIMEOUT > 1) ? $clog2(`PSX_ACK_TIMEOUT) : 1;
    localparam logic [ack_w-1:0] ack_last = ack_w'(`PSX_ACK_TIMEOUT - 1);
    localparam psx_pkg::psx_bit_idx_t bit_last = 3'd7;

    psx_pkg::xfer_state_t  state;
    psx_pkg::psx_bit_idx_t bit_idx;
    psx_pkg::psx_byte_t    shift_tx;   // remaining command bits, lsb next
    logic                  want_ack_q;
    logic [ack_w-1:0]      ack_cnt;
    logic                  last_rise;

    // eighth rising edge of the byte
    assign last_rise = (state == psx_pkg::xfer_shift) && rise_stb && (bit_idx == bit_last);

    always_ff @(posedge ack or negedge rst_n) begin
        if (!rst_n) begin
            state       <= psx_pkg::xfer_idle;
            bit_idx     <= '0;
            run         <= 1'b0;
            cmd         <= 1'b1;
            byte_done   <= 1'b0;
            ack_missing <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            case (state)
                psx_pkg::xfer_idle: begin
                    if (byte_start) begin
                        bit_idx <= '0;
                        run     <= 1'b1;
                        state   <= psx_pkg::xfer_shift;
                    end
                end
                psx_pkg::xfer_shift: begin
                    if (fall_stb) begin
                        cmd <= shift_tx[0];
                    end
                    if (last_rise) begin
                        run <= 1'b0;  // psx_clk parks high
                        cmd <= 1'b1;
                        if (want_ack_q) begin
                            state <= psx_pkg::xfer_wait_ack;
                        end else begin
                            byte_done   <= 1'b1;
                            ack_missing <= 1'b0;
                            state       <= psx_pkg::xfer_idle;
                        end
                    end else if (rise_stb) begin
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                psx_pkg::xfer_wait_ack: begin
                    if (!pad_ack) begin
                        byte_done   <= 1'b1;
                        ack_missing <= 1'b0;
                        state       <= psx_pkg::xfer_idle;
                    end else if (ack_cnt == ack_last) begin
                        byte_done   <= 1'b1;
                        ack_missing <= 1'b1;  // pad gave up or is absent
                        state       <= psx_pkg::xfer_idle;
                    end
                end
                default: state <= psx_pkg::xfer_idle;
            endcase
        end
    end

    // datapath
    always_ff @(posedge ack) begin
        if ((state == psx_pkg::xfer_idle) && byte_start) begin
            shift_tx   <= tx_byte;
            want_ack_q <= want_ack;
        end else if ((state == psx_pkg::xfer_shift) && fall_stb) begin
            shift_tx <= {1'b1, shift_tx[7:1]};
        end
        if ((state == psx_pkg::xfer_shift) && rise_stb) begin
            rx_byte <= {data, rx_byte[7:1]};  // lsb arrives first
        end
        if (state == psx_pkg::xfer_wait_ack) begin
            ack_cnt <= ack_cnt + 1'b1;
        end else begin
            ack_cnt <= '0;
        end
    end

endmodule

/* logic/psx_poll_seq.sv */
`timescale 1ns/1ps
`include "psx_params.svh"

module psx_poll_seq (
    input  logic                  ack,
    input  logic                  rst_n,
    input  logic                  poll_enable,
    input  logic                  credit_return,  // one credit per pulse
    input  logic                  byte_done,
    input  psx_pkg::psx_byte_t    rx_byte,
    input  logic                  ack_missing,
    output logic                  att,            // active low select
    output logic                  byte_start,
    output psx_pkg::psx_byte_t    tx_byte,
    output logic                  want_ack,
    output logic                  result_valid,
    output psx_pkg::psx_byte_t    result_id,
    output psx_pkg::psx_buttons_t result_buttons,
    output logic                  result_err
);

    localparam int wait_max = (`PSX_SELECT_DELAY > `PSX_POLL_GAP) ?
                              `PSX_SELECT_DELAY : `PSX_POLL_GAP;
    localparam int wait_w = $clog2(wait_max + 1);
    localparam logic [wait_w-1:0] select_last = wait_w'(`PSX_SELECT_DELAY - 1);
    localparam logic [wait_w-1:0] gap_last = wait_w'(`PSX_POLL_GAP - 1);
    localparam logic [2:0] last_byte = 3'd4;   // five bytes, 0..4

    psx_pkg::poll_state_t state;
    psx_pkg::psx_credit_t credits;
    logic [2:0]           byte_idx;
    logic [2:0]           next_idx;
    logic [wait_w-1:0]    wait_cnt;
    logic                 poll_go;
    logic                 first_issue;
    logic                 byte_bad;
    logic                 next_issue;

    // command byte for each position in the poll
    function automatic psx_pkg::psx_byte_t cmd_byte(input logic [2:0] idx);
        case (idx)
            3'd0:    cmd_byte = `PSX_CMD_START;
            3'd1:    cmd_byte = `PSX_CMD_POLL;
            default: cmd_byte = 8'h00;  // pad ignores cmd during button bytes
        endcase
    endfunction

    assign poll_go     = (state == psx_pkg::poll_idle) && poll_enable && (credits != '0);
    assign next_idx    = byte_idx + 3'd1;
    assign first_issue = (state == psx_pkg::poll_select) && (wait_cnt == select_last);
    assign byte_bad    = ack_missing || ((byte_idx == 3'd2) && (rx_byte != `PSX_MARKER));
    assign next_issue  = (state == psx_pkg::poll_bytes) && byte_done && !byte_bad &&
                         (byte_idx != last_byte);

    always_ff @(posedge ack or negedge rst_n) begin
        if (!rst_n) begin
            state        <= psx_pkg::poll_idle;
            att          <= 1'b1;
            byte_start   <= 1'b0;
            byte_idx     <= '0;
            wait_cnt     <= '0;
            result_valid <= 1'b0;
            result_err   <= 1'b0;
        end else begin
            byte_start   <= first_issue || next_issue;
            result_valid <= 1'b0;
            case (state)
                psx_pkg::poll_idle: begin
                    if (poll_go) begin
                        att        <= 1'b0;
                        wait_cnt   <= '0;
                        byte_idx   <= '0;
                        result_err <= 1'b0;
                        state      <= psx_pkg::poll_select;
                    end
                end
                psx_pkg::poll_select: begin
                    if (first_issue) begin
                        state <= psx_pkg::poll_bytes;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                psx_pkg::poll_bytes: begin
                    if (byte_done) begin
                        if (byte_bad) begin
                            result_err <= 1'b1;   // abort the rest of the poll
                            state      <= psx_pkg::poll_finish;
                        end else if (byte_idx == last_byte) begin
                            state <= psx_pkg::poll_finish;
                        end else begin
                            byte_idx <= next_idx;
                        end
                    end
                end
                psx_pkg::poll_finish: begin
                    result_valid <= 1'b1;
                    att          <= 1'b1;  // deselect with the result
                    wait_cnt     <= '0;
                    state        <= psx_pkg::poll_gap;
                end
                psx_pkg::poll_gap: begin
                    if (wait_cnt == gap_last) begin
                        state <= psx_pkg::poll_idle;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: state <= psx_pkg::poll_idle;
            endcase
        end
    end

    // a return and a start in the same cycle leave the count alone
    always_ff @(posedge ack or negedge rst_n) begin
        if (!rst_n) begin
            credits <= psx_pkg::psx_credit_t'(`PSX_INIT_CREDITS);
        end else begin
            case ({credit_return, poll_go})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // command and reply bytes
    always_ff @(posedge ack) begin
        if (first_issue) begin
            tx_byte  <= cmd_byte(3'd0);
            want_ack <= 1'b1;
        end else if (next_issue) begin
            tx_byte  <= cmd_byte(next_idx);
            want_ack <= (next_idx != last_byte);  // last byte has no ack
        end
        if ((state == psx_pkg::poll_bytes) && byte_done) begin
            case (byte_idx)
                3'd1:    result_id            <= rx_byte;
                3'd3:    result_buttons[7:0]  <= rx_byte;
                3'd4:    result_buttons[15:8] <= rx_byte;
                default: result_id            <= result_id;
            endcase
        end
    end

endmodule

/* logic/psx_pad_host.sv */
`timescale 1ns/1ps
`include "psx_params.svh"

module psx_pad_host (
    input  logic                  ack,
    input  logic                  rst_n,
    input  logic                  poll_enable,
    input  logic                  credit_return,
    input  logic                  data,
    input  logic                  pad_ack,
    output logic                  att,
    output logic                  cmd,
    output logic                  psx_clk,
    output logic                  result_valid,
    output psx_pkg::psx_byte_t    result_id,
    output psx_pkg::psx_buttons_t result_buttons,
    output logic                  result_err
);

    logic               run;
    logic               fall_stb;
    logic               rise_stb;
    logic               byte_start;
    psx_pkg::psx_byte_t tx_byte;
    logic               want_ack;
    psx_pkg::psx_byte_t rx_byte;
    logic               byte_done;
    logic               ack_missing;

    psx_clk_gen u_clk_gen (
        .ack      (ack),
        .rst_n    (rst_n),
        .run      (run),
        .psx_clk  (psx_clk),
        .fall_stb (fall_stb),
        .rise_stb (rise_stb)
    );

    psx_byte_xfer u_byte_xfer (
        .ack         (ack),
        .rst_n       (rst_n),
        .byte_start  (byte_start),
        .tx_byte     (tx_byte),
        .want_ack    (want_ack),
        .fall_stb    (fall_stb),
        .rise_stb    (rise_stb),
        .data        (data),
        .pad_ack     (pad_ack),
        .run         (run),
        .cmd         (cmd),
        .rx_byte     (rx_byte),
        .byte_done   (byte_done),
        .ack_missing (ack_missing)
    );

    psx_poll_seq u_poll_seq (
        .ack            (ack),
        .rst_n          (rst_n),
        .poll_enable    (poll_enable),
        .credit_return  (credit_return),
        .byte_done      (byte_done),
        .rx_byte        (rx_byte),
        .ack_missing    (ack_missing),
        .att            (att),
        .byte_start     (byte_start),
        .tx_byte        (tx_byte),
        .want_ack       (want_ack),
        .result_valid   (result_valid),
        .result_id      (result_id),
        .result_buttons (result_buttons),
        .result_err     (result_err)
    );

endmodule

/* test/psx_pad_model.sv */
`timescale 1ns/1ps

module psx_pad_model (
    input  logic                  ack,
    input  logic                  att,
    input  logic                  cmd,
    input  logic                  psx_clk,
    input  psx_pkg::psx_byte_t    pad_id,
    input  psx_pkg::psx_byte_t    marker,
    input  psx_pkg::psx_buttons_t buttons,    // low byte goes out first
    input  logic                  silent,     // never pulse pad_ack
    output logic                  data,
    output logic                  pad_ack,
    output logic [39:0]           cmd_seen,   // command byte k in bits 8k+7..8k
    output logic [2:0]            cmd_count
);

    psx_pkg::psx_byte_t reply;
    psx_pkg::psx_byte_t cmd_sr;
    logic [2:0]         bit_cnt;
    logic [2:0]         byte_cnt;

    function automatic psx_pkg::psx_byte_t reply_byte(input logic [2:0] idx);
        case (idx)
            3'd0:    reply_byte = 8'hFF;
            3'd1:    reply_byte = pad_id;
            3'd2:    reply_byte = marker;
            3'd3:    reply_byte = buttons[7:0];
            default: reply_byte = buttons[15:8];
        endcase
    endfunction

    // the pad answers one bit per falling psx_clk while it listens
    initial begin
        data      = 1'b1;
        cmd_seen  = '0;
        cmd_count = '0;
        bit_cnt   = '0;
        byte_cnt  = '0;
        cmd_sr    = '0;
        reply     = 8'hFF;
        forever begin
            @(negedge psx_clk or posedge att);
            #1;                        // cmd moves with the same edge
            if (att) begin
                bit_cnt  = '0;
                byte_cnt = '0;
                data     = 1'b1;       // line released between polls
            end else begin
                if ((bit_cnt == 3'd0) && (byte_cnt == 3'd0)) begin
                    cmd_seen  = '0;    // new poll
                    cmd_count = '0;
                end
                if (bit_cnt == 3'd0) begin
                    reply = reply_byte(byte_cnt);
                end
                data = reply[bit_cnt]; // lsb first
                cmd_sr = {cmd, cmd_sr[7:1]};
                if (bit_cnt == 3'd7) begin
                    cmd_seen[byte_cnt*8 +: 8] = cmd_sr;
                    cmd_count = cmd_count + 3'd1;
                    byte_cnt  = byte_cnt + 3'd1;
                end
                bit_cnt = bit_cnt + 3'd1;
            end
        end
    end

    // a wrapped bit counter at a rising edge marks the end of a byte
    initial begin
        pad_ack = 1'b1;
        forever begin
            @(posedge psx_clk);
            if (!att && !silent && (bit_cnt == 3'd0) && (byte_cnt != 3'd0) &&
                (byte_cnt != 3'd5)) begin
                repeat (2) @(posedge ack);
                #1;
                pad_ack = 1'b0;
                repeat (2) @(posedge ack);  // two system clocks low
                #1;
                pad_ack = 1'b1;
            end
        end
    end

endmodule

/* test/tb_psx_pad_host.sv */
`timescale 1ns/1ps
`include "psx_params.svh"

module tb_psx_pad_host;

    localparam int n_rows = 6;
    localparam int credit_polls = 3;          // polls in the credit test
    localparam int poll_limit = 1500;         // cycles allowed per poll
    localparam int cycle_limit = (n_rows + credit_polls) * poll_limit;
    localparam int quiet_cycles = 400;
    localparam logic [39:0] cmd_ref = 40'h00_0000_4201;  // 01 42 00 00 00

    typedef struct packed {
        psx_pkg::psx_byte_t    id;
        psx_pkg::psx_byte_t    marker;
        psx_pkg::psx_buttons_t buttons;
        logic                  silent;
        psx_pkg::psx_byte_t    exp_id;
        psx_pkg::psx_buttons_t exp_buttons;
        logic                  exp_err;
    } row_t;

    logic ack, rst_n, poll_enable, credit_return, data, pad_ack;
    logic att, cmd, psx_clk, result_valid, result_err;
    psx_pkg::psx_byte_t    result_id;
    psx_pkg::psx_buttons_t result_buttons;
    psx_pkg::psx_byte_t    pad_id, marker;
    psx_pkg::psx_buttons_t buttons;
    logic                  silent;
    logic [39:0]           cmd_seen;
    logic [2:0]            cmd_count;
    row_t                  rows [n_rows];
    int seed, error_count, check_count;
    int cycle_count = 0;

    psx_pad_host u_dut (
        .ack (ack), .rst_n (rst_n), .poll_enable (poll_enable),
        .credit_return (credit_return), .data (data), .pad_ack (pad_ack),
        .att (att), .cmd (cmd), .psx_clk (psx_clk), .result_valid (result_valid),
        .result_id (result_id), .result_buttons (result_buttons), .result_err (result_err)
    );

    psx_pad_model u_pad (
        .ack (ack), .att (att), .cmd (cmd), .psx_clk (psx_clk), .pad_id (pad_id),
        .marker (marker), .buttons (buttons), .silent (silent), .data (data),
        .pad_ack (pad_ack), .cmd_seen (cmd_seen), .cmd_count (cmd_count)
    );

    initial begin
        ack = 1'b0;
        forever #4 ack = ~ack;
    end

    always @(posedge ack) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the run did not complete", cycle_limit);
            $display("checks: %0d, errors: %0d", check_count, error_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic tick;
        @(posedge ack);
        #1;                                   // inputs change once outputs have settled
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    function automatic row_t make_row(input psx_pkg::psx_byte_t id,
                                      input psx_pkg::psx_byte_t mark,
                                      input logic quiet, input logic err);
        psx_pkg::psx_buttons_t btn;
        btn = 16'($random(seed));
        make_row = '{id, mark, btn, quiet, id, btn, err};
    endfunction

    // a silent pad stops the poll after byte one and a bad marker after byte three
    function automatic int expected_cmd_bytes(input logic quiet, input logic bad_marker);
        if (quiet) begin
            return 1;
        end
        return bad_marker ? 3 : 5;
    endfunction

    task automatic wait_result(output logic seen);
        int n;
        seen = 1'b0;
        for (n = 0; (n < poll_limit) && !seen; n++) begin
            tick();
            seen = (result_valid === 1'b1);
        end
        if (!seen) begin
            error_count++;
            $display("no result_valid arrived within %0d cycles", poll_limit);
        end
    endtask

    task automatic watch_quiet(input int cycles);
        int n;
        logic bad;
        bad = 1'b0;
        for (n = 0; (n < cycles) && !bad; n++) begin
            tick();
            if ((att !== 1'b1) || (result_valid !== 1'b0)) begin
                bad = 1'b1;
                compare_value("att", 32'(att), 32'd1);
                compare_value("result_valid", 32'(result_valid), 32'd0);
            end
        end
    endtask

    task automatic check_cmd_bytes(input int count);
        int k;
        compare_value("cmd_count", 32'(cmd_count), 32'(count));
        for (k = 0; k < count; k++) begin
            compare_value($sformatf("cmd byte %0d", k), 32'(cmd_seen[k*8 +: 8]),
                          32'(cmd_ref[k*8 +: 8]));
        end
    endtask

    task automatic run_row(input row_t r);
        logic seen;
        pad_id = r.id;
        marker = r.marker;
        buttons = r.buttons;
        silent = r.silent;
        poll_enable = 1'b1;
        wait_result(seen);
        poll_enable = 1'b0;                   // next poll waits for the next row
        if (seen) begin
            compare_value("result_err", 32'(result_err), 32'(r.exp_err));
            compare_value("att", 32'(att), 32'd1);
            if (!r.exp_err) begin
                compare_value("result_id", 32'(result_id), 32'(r.exp_id));
                compare_value("result_buttons", 32'(result_buttons), 32'(r.exp_buttons));
            end
            check_cmd_bytes(expected_cmd_bytes(r.silent, r.marker != 8'h5A));
        end
        tick();
        credit_return = 1'b1;
        tick();
        credit_return = 1'b0;
    endtask

    initial begin
        int i;
        logic seen;
        rst_n = 1'b0;
        poll_enable = 1'b0;
        credit_return = 1'b0;
        pad_id = 8'h00;
        marker = 8'h5A;
        buttons = 16'hFFFF;
        silent = 1'b0;
        error_count = 0;
        check_count = 0;
        seed = 72;
        rows[0] = make_row(8'h41, 8'h5A, 1'b0, 1'b0);
        rows[1] = make_row(8'h73, 8'h5A, 1'b0, 1'b0);
        rows[2] = make_row(8'h41, 8'h5A, 1'b1, 1'b1);  // pad stays silent
        rows[3] = make_row(8'h41, 8'hA5, 1'b0, 1'b1);  // wrong marker
        rows[4] = make_row(8'h73, 8'h5A, 1'b0, 1'b0);
        rows[5] = make_row(8'h41, 8'h5A, 1'b0, 1'b0);
        repeat (4) @(posedge ack);
        #1;
        rst_n = 1'b1;
        repeat (3) tick();
        compare_value("att", 32'(att), 32'd1);
        compare_value("cmd", 32'(cmd), 32'd1);
        compare_value("psx_clk", 32'(psx_clk), 32'd1);
        compare_value("result_valid", 32'(result_valid), 32'd0);
        for (i = 0; i < n_rows; i++) begin
            run_row(rows[i]);
        end
        // all credits are back so hold poll_enable until they run out
        silent = 1'b0;
        marker = 8'h5A;
        poll_enable = 1'b1;
        for (i = 0; i < `PSX_INIT_CREDITS; i++) begin
            wait_result(seen);
        end
        watch_quiet(quiet_cycles);
        credit_return = 1'b1;
        tick();
        credit_return = 1'b0;
        wait_result(seen);
        if (seen) begin
            compare_value("result_err", 32'(result_err), 32'd0);
        end
        watch_quiet(quiet_cycles);
        poll_enable = 1'b0;
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+logic
logic/psx_pkg.sv
logic/psx_clk_gen.sv
logic/psx_byte_xfer.sv
logic/psx_poll_seq.sv
logic/psx_pad_host.sv
test/psx_pad_model.sv
test/tb_psx_pad_host.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log_file=sim.log

if ! verilator --binary --timing --top-module tb_psx_pad_host \
        -f compile.f -Mdir "$obj_dir" -o tb_psx_pad_host; then
    echo "verilator build failed"
    exit 1
fi

"./$obj_dir/tb_psx_pad_host" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$log_file"; then
    exit 0
fi
echo "pass message not found in $log_file"
exit 1
